// ==== Makefile ====
TOP := apb_bus_monitor_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f flist.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log

// ==== dv/apb_bus_monitor_props.sv ====
`default_nettype none

module apb_bus_monitor_props (
    input wire       apb_if_monitor,
    input wire       rst,
    input wire       psel,
    input wire       penable,
    input wire       pready,
    input wire       wb_cyc,
    input wire       wb_stb,
    input wire       wb_ack,
    input wire       xfer_done,
    input wire [3:0] viol_pulse,
    input wire       count_clear
);

    ack_one_cycle: assert property (
        @(posedge apb_if_monitor) disable iff (rst) wb_ack |=> !wb_ack
    ) else $error("wb_ack stayed high for more than one cycle");

    ack_after_request: assert property (
        @(posedge apb_if_monitor) disable iff (rst) wb_ack |-> $past(wb_cyc && wb_stb)
    ) else $error("wb_ack without a preceding wb_cyc and wb_stb");

    // done pulse trails the completing cycle by one edge
    done_after_complete: assert property (
        @(posedge apb_if_monitor) disable iff (rst)
        xfer_done |-> $past(psel && penable && pready)
    ) else $error("xfer_done without a completing apb cycle");

    quiet_in_reset: assert property (
        @(posedge apb_if_monitor)
        rst |=> !wb_ack && !xfer_done && (viol_pulse == 4'b0) && !count_clear
    ) else $error("monitor outputs active while in reset");

endmodule

bind apb_bus_monitor apb_bus_monitor_props i_apb_bus_monitor_props (
    .apb_if_monitor (apb_if_monitor),
    .rst            (rst),
    .psel           (psel),
    .penable        (penable),
    .pready         (pready),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_ack         (wb_ack),
    .xfer_done      (xfer_done),
    .viol_pulse     (viol_pulse),
    .count_clear    (count_clear)
);

`default_nettype wire

// ==== dv/apb_bus_monitor_tb.sv ====
`default_nettype none

`include "apb_mon_defines.svh"

module apb_bus_monitor_tb
    import apb_mon_pkg::*;
;

    logic                       apb_if_monitor = 1'b0;
    logic                       rst;
    logic                       presetn;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
    logic [`APB_DATA_WIDTH-1:0] prdata;
    logic                       pready;
    logic                       pslverr;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [`WB_ADDR_WIDTH-1:0]  wb_adr;
    logic [`APB_DATA_WIDTH-1:0] wb_wdata;
    logic                       wb_ack;
    logic [`APB_DATA_WIDTH-1:0] wb_rdata;

    integer           seed = 32'h1be30d29;
    int               fd;
    int               rc;
    int               golden_lines = 0;
    int               lines_counted;
    reg [8*160-1:0]   text;
    reg [8*32-1:0]    test_name;
    logic             in_test = 1'b0;
    int               test_checks = 0;
    int               test_errors = 0;
    int               total_tests = 0;
    int               total_checks = 0;
    int               total_errors = 0;

    apb_bus_monitor i_apb_bus_monitor (
        .apb_if_monitor (apb_if_monitor),
        .rst            (rst),
        .presetn        (presetn),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_wdata       (wb_wdata),
        .wb_ack         (wb_ack),
        .wb_rdata       (wb_rdata)
    );

    always #4 apb_if_monitor = ~apb_if_monitor;

    // setup, optional wait states, then the completing access cycle
    task automatic apb_transfer(input logic dir_write, input logic [31:0] addr,
                                input int waits, input logic err);
        int i;
        @(posedge apb_if_monitor);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= dir_write;
        paddr   <= addr;
        pwdata  <= $random(seed);
        @(posedge apb_if_monitor);
        penable <= 1'b1;
        pready  <= (waits == 0);
        pslverr <= (waits == 0) && err;
        for (i = 1; i <= waits; i++) begin
            @(posedge apb_if_monitor);
            pready  <= (i == waits);
            pslverr <= (i == waits) && err;
        end
        @(posedge apb_if_monitor);
        psel    <= 1'b0;
        penable <= 1'b0;
        pready  <= 1'b0;
        pslverr <= 1'b0;
        repeat (4) @(posedge apb_if_monitor);
    endtask

    // each case breaks exactly one rule for one cycle
    task automatic inject_violation(input apb_viol_t kind);
        @(posedge apb_if_monitor);
        pwrite <= 1'b1;
        paddr  <= 32'h6000_0000;
        pwdata <= $random(seed);
        case (kind)
            viol_no_enable: begin
                psel    <= 1'b1;
                penable <= 1'b0;
                repeat (2) @(posedge apb_if_monitor);
                psel <= 1'b0;
            end
            viol_unstable: begin
                psel    <= 1'b1;
                penable <= 1'b0;
                @(posedge apb_if_monitor);
                penable <= 1'b1;
                paddr   <= 32'h6000_0004;
                @(posedge apb_if_monitor);
                psel    <= 1'b0;
                penable <= 1'b0;
            end
            viol_enable_held: begin
                // completes into bin 0x26 as a side effect
                psel    <= 1'b1;
                penable <= 1'b0;
                @(posedge apb_if_monitor);
                penable <= 1'b1;
                pready  <= 1'b1;
                @(posedge apb_if_monitor);
                pready <= 1'b0;
                @(posedge apb_if_monitor);
                psel    <= 1'b0;
                penable <= 1'b0;
            end
            default: begin
                penable <= 1'b1;
                @(posedge apb_if_monitor);
                penable <= 1'b0;
            end
        endcase
        repeat (4) @(posedge apb_if_monitor);
    endtask

    task automatic wb_access(input logic we, input logic [`WB_ADDR_WIDTH-1:0] adr,
                             input logic [31:0] data, output logic [31:0] rdata);
        int   wait_cycles;
        logic got_ack;
        wait_cycles = 0;
        got_ack = 1'b0;
        @(posedge apb_if_monitor);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdata <= data;
        while (!got_ack && wait_cycles < 8) begin
            @(posedge apb_if_monitor);
            wait_cycles++;
            got_ack = wb_ack;
        end
        rdata = wb_rdata;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        test_checks++;
        assert (got_ack) else begin
            $display("wishbone access to word %0h was never acknowledged", adr);
            test_errors++;
        end
    endtask

    task automatic check_read(input logic [31:0] adr, input logic [31:0] expected,
                              input logic [31:0] actual);
        test_checks++;
        assert (actual == expected) else begin
            $display("error %0s: word %0h expected %h, actual %h",
                     test_name, adr, expected, actual);
            test_errors++;
        end
    endtask

    task automatic end_test();
        if (in_test) begin
            $display("test %0s: %0d checks, %0d errors", test_name, test_checks, test_errors);
            total_tests++;
        end
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
        in_test = 1'b0;
    endtask

    task automatic run_golden();
        logic [7:0]  cmd;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_c;
        logic [31:0] f_d;
        logic [31:0] rd;
        logic        done;
        done = 1'b0;
        while (!done) begin
            rc = $fscanf(fd, " %c", cmd);
            if (rc != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": rc = $fgets(text, fd);
                    "T": begin
                        end_test();
                        rc = $fscanf(fd, "%s", test_name);
                        in_test = 1'b1;
                    end
                    "A": begin
                        rc = $fscanf(fd, "%d %h %d %d", f_a, f_b, f_c, f_d);
                        apb_transfer(f_a[0], f_b, f_c, f_d[0]);
                    end
                    "V": begin
                        rc = $fscanf(fd, "%d", f_a);
                        inject_violation(apb_viol_t'(f_a[1:0]));
                    end
                    "W": begin
                        rc = $fscanf(fd, "%h %h", f_a, f_b);
                        wb_access(1'b1, f_a[`WB_ADDR_WIDTH-1:0], f_b, rd);
                    end
                    "R": begin
                        rc = $fscanf(fd, "%h %h", f_a, f_b);
                        wb_access(1'b0, f_a[`WB_ADDR_WIDTH-1:0], 32'h0, rd);
                        check_read(f_a, f_b, rd);
                    end
                    default: begin
                        $display("golden file holds an unknown command %c", cmd);
                        test_errors++;
                    end
                endcase
            end
        end
    endtask

    initial begin
        rst      <= 1'b1;
        presetn  <= 1'b0;
        psel     <= 1'b0;
        penable  <= 1'b0;
        pwrite   <= 1'b0;
        paddr    <= '0;
        pwdata   <= '0;
        prdata   <= '0;
        pready   <= 1'b0;
        pslverr  <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_wdata <= '0;
        lines_counted = 0;
        fd = $fopen("dv/apb_mon_golden.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                rc = $fgets(text, fd);
                if (rc > 0) begin
                    lines_counted++;
                end
            end
            $fclose(fd);
            fd = $fopen("dv/apb_mon_golden.txt", "r");
        end
        golden_lines = lines_counted;
        if (fd == 0) begin
            $display("the golden file dv/apb_mon_golden.txt could not be opened");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            repeat (2) @(posedge apb_if_monitor);
            rst     <= 1'b0;
            presetn <= 1'b1;
            run_golden();
            end_test();
            $fclose(fd);
            $display("%0d tests, %0d checks, %0d errors", total_tests, total_checks,
                     total_errors);
            if (total_errors == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

    // budget of 40 cycles per golden line
    initial begin
        wait (golden_lines > 0);
        repeat (golden_lines * 40) @(posedge apb_if_monitor);
        $display("timeout: the golden run did not finish within %0d cycles", golden_lines * 40);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/apb_mon_golden.txt ====
# T name | A pwrite paddr waits pslverr (pwdata is random) | V violation code
# W word_addr data | R word_addr expected  (addresses and data in hex)
T reset_values
R 00 0
R 25 0
R 3f 0
R 40 0
R 41 0
R 42 1
T write_bins
A 1 10000000 0 0
A 1 10000010 3 0
A 1 a0000000 1 0
A 1 f0000000 2 0
R 21 2
R 2a 1
R 2f 1
R 20 0
R 01 0
T read_bins
A 0 30000000 0 0
A 0 30000000 2 1
A 0 c0000000 1 1
R 03 1
R 13 1
R 1c 1
R 0c 0
T violations
V 0
V 1
V 2
V 3
R 40 f
R 41 4
R 26 1
W 40 5
R 40 a
W 40 a
R 40 0
T enable_clear
W 42 0
R 42 0
A 1 10000000 0 0
R 21 2
W 42 3
R 42 1
R 21 0
R 03 0
R 41 0
A 1 10000000 1 0
R 21 1

// ==== flist.f ====
+incdir+verilog
verilog/apb_mon_pkg.sv
verilog/apb_phase_tracker.sv
verilog/apb_cov_counters.sv
verilog/apb_mon_wb_regs.sv
verilog/apb_bus_monitor.sv
dv/apb_bus_monitor_props.sv
dv/apb_bus_monitor_tb.sv

// ==== verilog/apb_bus_monitor.sv ====
`default_nettype none

`include "apb_mon_defines.svh"

module apb_bus_monitor
    import apb_mon_pkg::*;
(
    input  wire                        apb_if_monitor,
    input  wire                        rst,
    input  wire                        presetn,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire [`APB_ADDR_WIDTH-1:0]  paddr,
    input  wire [`APB_DATA_WIDTH-1:0]  pwdata,
    input  wire [`APB_DATA_WIDTH-1:0]  prdata,
    input  wire                        pready,
    input  wire                        pslverr,
    input  wire                        wb_cyc,
    input  wire                        wb_stb,
    input  wire                        wb_we,
    input  wire [`WB_ADDR_WIDTH-1:0]   wb_adr,
    input  wire [`APB_DATA_WIDTH-1:0]  wb_wdata,
    output logic                       wb_ack,
    output logic [`APB_DATA_WIDTH-1:0] wb_rdata
);

    logic                               xfer_done;
    bin_idx_t                           xfer_bin;
    viol_vec_t                          viol_pulse;
    logic                               count_enable;
    logic                               count_clear;
    logic [`BIN_COUNT*`COUNT_WIDTH-1:0] bin_counts;
    logic [`COUNT_WIDTH-1:0]            viol_total;

    // prdata is part of the bus but the checks never look at it
    apb_phase_tracker i_apb_phase_tracker (
        .apb_if_monitor (apb_if_monitor),
        .rst            (rst),
        .presetn        (presetn),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .xfer_done      (xfer_done),
        .xfer_bin       (xfer_bin),
        .viol_pulse     (viol_pulse)
    );

    apb_cov_counters i_apb_cov_counters (
        .apb_if_monitor (apb_if_monitor),
        .rst            (rst),
        .xfer_done      (xfer_done),
        .xfer_bin       (xfer_bin),
        .viol_pulse     (viol_pulse),
        .count_enable   (count_enable),
        .count_clear    (count_clear),
        .bin_counts     (bin_counts),
        .viol_total     (viol_total)
    );

    apb_mon_wb_regs i_apb_mon_wb_regs (
        .apb_if_monitor (apb_if_monitor),
        .rst            (rst),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_wdata       (wb_wdata),
        .wb_ack         (wb_ack),
        .wb_rdata       (wb_rdata),
        .viol_pulse     (viol_pulse),
        .bin_counts     (bin_counts),
        .viol_total     (viol_total),
        .count_enable   (count_enable),
        .count_clear    (count_clear)
    );

endmodule

`default_nettype wire

// ==== verilog/apb_cov_counters.sv ====
`default_nettype none

`include "apb_mon_defines.svh"

module apb_cov_counters
    import apb_mon_pkg::*;
(
    input  wire                                  apb_if_monitor,
    input  wire                                  rst,
    input  wire                                  xfer_done,
    input  wire bin_idx_t                        xfer_bin,
    input  wire viol_vec_t                       viol_pulse,
    input  wire                                  count_enable,
    input  wire                                  count_clear,
    output logic [`BIN_COUNT*`COUNT_WIDTH-1:0]   bin_counts,
    output logic [`COUNT_WIDTH-1:0]              viol_total
);

    logic [`COUNT_WIDTH-1:0] bin_q [`BIN_COUNT];

    logic bin_inc;
    logic total_inc;

    // stop at all ones
    assign bin_inc   = count_enable && xfer_done && (bin_q[xfer_bin] != '1);
    assign total_inc = count_enable && (|viol_pulse) && (viol_total != '1);

    always_ff @(posedge apb_if_monitor) begin
        if (rst || count_clear) begin
            for (int i = 0; i < `BIN_COUNT; i++) begin
                bin_q[i] <= '0;
            end
        end else if (bin_inc) begin
            bin_q[xfer_bin] <= bin_q[xfer_bin] + 1'b1;
        end
    end

    // one count per cycle with any check firing
    always_ff @(posedge apb_if_monitor) begin
        if (rst || count_clear) begin
            viol_total <= '0;
        end else if (total_inc) begin
            viol_total <= viol_total + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < `BIN_COUNT; i++) begin
            bin_counts[i*`COUNT_WIDTH +: `COUNT_WIDTH] = bin_q[i];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/apb_mon_defines.svh ====
`ifndef APB_MON_DEFINES_SVH
`define APB_MON_DEFINES_SVH

// apb bus widths
`define APB_ADDR_WIDTH 32
`define APB_DATA_WIDTH 32

// top address bits that pick the region
`define REGION_WIDTH 4

// saturating counters
`define COUNT_WIDTH 16
`define BIN_COUNT 64

// wishbone word address
`define WB_ADDR_WIDTH 7

// register map in word addresses
`define REG_BIN_BASE 0
`define REG_VIOL_FLAGS 64
`define REG_VIOL_TOTAL 65
`define REG_CTRL 66

`endif

// ==== verilog/apb_mon_pkg.sv ====
`default_nettype none

`include "apb_mon_defines.svh"

package apb_mon_pkg;

    // monitor view of the transfer
    typedef enum logic [1:0] {
        phase_idle   = 2'd0,
        phase_setup  = 2'd1,
        phase_access = 2'd2
    } apb_phase_t;

    // bit positions in the flag word
    typedef enum logic [1:0] {
        viol_no_enable        = 2'd0,
        viol_unstable         = 2'd1,
        viol_enable_held      = 2'd2,
        viol_enable_no_select = 2'd3
    } apb_viol_t;

    typedef logic [3:0] viol_vec_t;

    // {pwrite, pslverr, region}
    typedef logic [$clog2(`BIN_COUNT)-1:0] bin_idx_t;

endpackage

`default_nettype wire

// ==== verilog/apb_mon_wb_regs.sv ====
`default_nettype none

`include "apb_mon_defines.svh"

module apb_mon_wb_regs
    import apb_mon_pkg::*;
(
    input  wire                                apb_if_monitor,
    input  wire                                rst,
    input  wire                                wb_cyc,
    input  wire                                wb_stb,
    input  wire                                wb_we,
    input  wire [`WB_ADDR_WIDTH-1:0]           wb_adr,
    input  wire [`APB_DATA_WIDTH-1:0]          wb_wdata,
    output logic                               wb_ack,
    output logic [`APB_DATA_WIDTH-1:0]         wb_rdata,
    input  wire viol_vec_t                     viol_pulse,
    input  wire [`BIN_COUNT*`COUNT_WIDTH-1:0]  bin_counts,
    input  wire [`COUNT_WIDTH-1:0]             viol_total,
    output logic                               count_enable,
    output logic                               count_clear
);

    logic                        wb_req;
    logic                        wr_flags;
    logic                        wr_ctrl;
    logic [`WB_ADDR_WIDTH-1:0]   bin_off;
    bin_idx_t                    bin_sel;
    viol_vec_t                   clr_mask;
    viol_vec_t                   flags_q;
    logic [`APB_DATA_WIDTH-1:0]  read_word;

    // new request only while no ack is out
    assign wb_req   = wb_cyc && wb_stb && !wb_ack;
    assign wr_flags = wb_req && wb_we && (wb_adr == `WB_ADDR_WIDTH'(`REG_VIOL_FLAGS));
    assign wr_ctrl  = wb_req && wb_we && (wb_adr == `WB_ADDR_WIDTH'(`REG_CTRL));

    assign count_clear = wr_ctrl && wb_wdata[1];
    assign clr_mask    = wr_flags ? viol_vec_t'(wb_wdata) : '0;

    assign bin_off = wb_adr - `WB_ADDR_WIDTH'(`REG_BIN_BASE);
    assign bin_sel = bin_idx_t'(bin_off);

    always_ff @(posedge apb_if_monitor) begin
        if (rst) begin
            wb_ack       <= 1'b0;
            count_enable <= 1'b1;
            flags_q      <= '0;
        end else begin
            wb_ack <= wb_req;
            if (wr_ctrl) begin
                count_enable <= wb_wdata[0];
            end
            // a fresh pulse beats a same-cycle clear
            flags_q <= (flags_q & ~clr_mask) | viol_pulse;
        end
    end

    always_comb begin
        read_word = '0;
        if (bin_off < `WB_ADDR_WIDTH'(`BIN_COUNT)) begin
            read_word = `APB_DATA_WIDTH'(bin_counts[bin_sel*`COUNT_WIDTH +: `COUNT_WIDTH]);
        end else begin
            case (wb_adr)
                `WB_ADDR_WIDTH'(`REG_VIOL_FLAGS): read_word = `APB_DATA_WIDTH'(flags_q);
                `WB_ADDR_WIDTH'(`REG_VIOL_TOTAL): read_word = `APB_DATA_WIDTH'(viol_total);
                `WB_ADDR_WIDTH'(`REG_CTRL):       read_word = `APB_DATA_WIDTH'(count_enable);
                default:                          read_word = '0;
            endcase
        end
    end

    // data lines up with the ack cycle
    always_ff @(posedge apb_if_monitor) begin
        if (wb_req) begin
            wb_rdata <= read_word;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/apb_phase_tracker.sv ====
`default_nettype none

`include "apb_mon_defines.svh"

module apb_phase_tracker
    import apb_mon_pkg::*;
(
    input  wire                       apb_if_monitor,
    input  wire                       rst,
    input  wire                       presetn,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire [`APB_ADDR_WIDTH-1:0] paddr,
    input  wire [`APB_DATA_WIDTH-1:0] pwdata,
    input  wire                       pready,
    input  wire                       pslverr,
    output logic                      xfer_done,
    output bin_idx_t                  xfer_bin,
    output viol_vec_t                 viol_pulse
);

    apb_phase_t state;
    apb_phase_t state_next;

    logic                       cap_write;
    logic [`APB_ADDR_WIDTH-1:0] cap_addr;
    logic [`APB_DATA_WIDTH-1:0] cap_wdata;

    logic      in_xfer;
    logic      complete;
    logic      changed;
    viol_vec_t viol_now;

    // fsm lags the bus by one edge, so setup state is the first access cycle
    assign in_xfer  = (state == phase_setup) || (state == phase_access);
    assign complete = in_xfer && psel && penable && pready;

    assign changed = (paddr != cap_addr) || (pwrite != cap_write) ||
                     (cap_write && (pwdata != cap_wdata));

    always_comb begin
        state_next = state;
        case (state)
            phase_idle: begin
                // penable already high is not a real setup cycle
                if (psel && !penable) begin
                    state_next = phase_setup;
                end
            end
            phase_setup: begin
                if (!psel || !penable || complete) begin
                    state_next = phase_idle;
                end else begin
                    state_next = phase_access;
                end
            end
            phase_access: begin
                if (!psel || complete) begin
                    state_next = phase_idle;
                end
            end
            default: begin
                state_next = phase_idle;
            end
        endcase
    end

    always_comb begin
        viol_now = '0;
        viol_now[viol_no_enable]        = (state == phase_setup) && !penable;
        viol_now[viol_unstable]         = in_xfer && psel && penable && changed;
        viol_now[viol_enable_held]      = xfer_done && penable;
        viol_now[viol_enable_no_select] = penable && !psel;
    end

    always_ff @(posedge apb_if_monitor) begin
        if (rst || !presetn) begin
            state      <= phase_idle;
            xfer_done  <= 1'b0;
            viol_pulse <= '0;
        end else begin
            state      <= state_next;
            xfer_done  <= complete;
            viol_pulse <= viol_now;
        end
    end

    // snapshot of the setup cycle
    always_ff @(posedge apb_if_monitor) begin
        if ((state == phase_idle) && (state_next == phase_setup)) begin
            cap_write <= pwrite;
            cap_addr  <= paddr;
            cap_wdata <= pwdata;
        end
        if (complete) begin
            xfer_bin <= {pwrite, pslverr, paddr[`APB_ADDR_WIDTH-1 -: `REGION_WIDTH]};
        end
    end

endmodule

`default_nettype wire
